// File: files.f
+incdir+source
source/warp_types_pkg.sv
source/irq_state_pkg.sv
source/irqc_ttu_if.sv
source/irq_controller.sv
source/drain_watchdog.sv
source/thread_transfer_unit.sv
source/warp_mask_table.sv
source/simt_irq_top.sv
bench/simt_irq_chk.sv
bench/simt_irq_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the interrupt path testbench with Verilator and runs it
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module simt_irq_tb \
	-Mdir obj_dir -o simt_irq_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

# a failing assertion should not end the run before the verdict is printed
./obj_dir/simt_irq_sim +verilator+error+limit+1000 > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
	exit 0
fi
exit 1

// File: bench/simt_irq_tb.sv
`default_nettype none

`include "simt_irq_params.svh"

module simt_irq_tb;
	import warp_types_pkg::*;

	// covers about 40 requests of at most the drain limit plus 40 cycles each
	localparam int TIMEOUT_CYCLES = 3000;

	typedef struct packed {
		logic abort;
		wmask_t active;
		tmask_t mask;
	} ref_result_t;

	logic clk;
	logic rst_n;
	logic irq_valid;
	warp_id_t irq_wid;
	thread_id_t irq_tid;
	pc_t isr_pc;
	logic no_pending_instr;
	wmask_t barrier_stalls;
	wmask_t ipdom_stack_empty;
	logic [`ISSUE_CNT-1:0] branch_valid;
	logic [`ISSUE_CNT-1:0] branch_taken;
	warp_id_t [`ISSUE_CNT-1:0] branch_wid;
	pc_t [`ISSUE_CNT-1:0] branch_dest;
	logic irq_busy;
	logic irq_done;
	logic irq_abort;
	logic scheduling_paused;
	wmask_t active_warps;
	tmask_t [`NUM_WARPS-1:0] thread_masks;
	pc_t [`NUM_WARPS-1:0] warp_pcs;

	// shadow of the warp table and the outcome expected for the request in flight
	wmask_t shadow_active;
	tmask_t [`NUM_WARPS-1:0] shadow_mask;
	pc_t [`NUM_WARPS-1:0] shadow_pc;
	ref_result_t exp_result;
	warp_id_t exp_wid;
	logic exp_abort;

	logic [31:0] lfsr_state;
	int mismatch_count = 0;
	int other_errors = 0;
	int done_count = 0;
	int abort_count = 0;
	int cycle_count = 0;

	simt_irq_top u_simt_irq_top (
		.clk(clk), .rst_n(rst_n), .irq_valid(irq_valid), .irq_wid(irq_wid),
		.irq_tid(irq_tid), .isr_pc(isr_pc), .no_pending_instr(no_pending_instr),
		.barrier_stalls(barrier_stalls), .ipdom_stack_empty(ipdom_stack_empty),
		.branch_valid(branch_valid), .branch_taken(branch_taken),
		.branch_wid(branch_wid), .branch_dest(branch_dest), .irq_busy(irq_busy),
		.irq_done(irq_done), .irq_abort(irq_abort),
		.scheduling_paused(scheduling_paused), .active_warps(active_warps),
		.thread_masks(thread_masks), .warp_pcs(warp_pcs)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// galois form with taps for x^32 + x^30 + x^26 + x^25 + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	// a thread can only move if its warp is live and it still owns the thread
	function automatic ref_result_t predict_transfer(input warp_id_t w, input thread_id_t t,
	                                                 input wmask_t act, input tmask_t mask_w);
		ref_result_t r;
		r.abort = !act[w] || !mask_w[t];
		r.active = act;
		r.mask = mask_w;
		if (!r.abort) begin
			r.mask = mask_w & ~(tmask_t'(1) << t);
			// a warp with no thread left is taken out of scheduling
			if (r.mask == '0) begin
				r.active = act & ~(wmask_t'(1) << w);
			end
		end
		return r;
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
	                           input string what);
		if (got !== exp) begin
			mismatch_count++;
			$display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic drive_lane(input int lane, input logic valid, input logic taken,
	                          input warp_id_t w, input pc_t dest);
		branch_valid[lane] <= valid;
		branch_taken[lane] <= taken;
		branch_wid[lane] <= w;
		branch_dest[lane] <= dest;
	endtask

	// each kind misses the ISR-done jump by exactly one field
	task automatic drive_decoy(input int lane, input warp_id_t w, input pc_t isr,
	                           input logic [1:0] kind);
		case (kind)
			2'd0: drive_lane(lane, 1'b1, 1'b1, w + 2'd1, isr);
			2'd1: drive_lane(lane, 1'b1, 1'b1, w, isr + 32'd4);
			2'd2: drive_lane(lane, 1'b1, 1'b0, w, isr);
			default: drive_lane(lane, 1'b0, 1'b1, w, isr);
		endcase
	endtask

	task automatic wait_abort(input int limit);
		int cycles;
		cycles = 0;
		while (!irq_abort && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!irq_abort) begin
			other_errors++;
			$display("request was not aborted within %0d cycles", limit);
		end
	endtask

	task automatic run_request(input warp_id_t w, input thread_id_t t, input logic blocked);
		logic [31:0] v;
		pc_t isr;
		int cycles;
		int decoys;
		int done_before;
		logic paused_prev;
		exp_result = predict_transfer(w, t, shadow_active, shadow_mask[w]);
		exp_wid = w;
		exp_abort = exp_result.abort || blocked;
		random_bits(10, v);
		// ISR entries sit well above every warp's own code
		isr = 32'h8000 + {22'd0, v[7:0], 2'b00};
		@(posedge clk);
		irq_valid <= 1'b1;
		irq_wid <= w;
		irq_tid <= t;
		isr_pc <= isr;
		no_pending_instr <= 1'b0;
		if (blocked) begin
			barrier_stalls <= wmask_t'(1) << v[9:8];
		end
		@(posedge clk);
		irq_valid <= 1'b0;
		// the pipeline still holds work in the first wait cycle and nothing may drain yet
		@(posedge clk);
		no_pending_instr <= 1'b1;
		if (exp_abort) begin
			wait_abort(`DRAIN_LIMIT + 1);
			@(posedge clk);
			barrier_stalls <= '0;
			return;
		end
		// the swap shows as the ISR address in the warp's PC slot
		cycles = 0;
		paused_prev = 1'b0;
		while (!(irq_busy && warp_pcs[w] == isr) && !irq_abort && cycles < 8) begin
			paused_prev = scheduling_paused;
			@(negedge clk);
			cycles++;
		end
		if (irq_abort || cycles == 8) begin
			other_errors++;
			$display("warp %0d thread %0d was never swapped to the ISR", w, t);
			return;
		end
		// one cycle to see the drain, one in PC_SWAP, and then the table holds the ISR
		check_value(32'(cycles), 32'd3, "cycles from drain to swap");
		check_value(32'(paused_prev), 32'd1, "scheduling_paused in PC_SWAP");
		check_value(32'(active_warps), 32'(wmask_t'(1) << w), "active_warps in ISR");
		check_value(32'(thread_masks[w]), 32'(tmask_t'(1) << t), "thread mask in ISR");
		// a second request while busy must leave no trace
		@(posedge clk);
		irq_valid <= 1'b1;
		irq_wid <= w + 2'd1;
		irq_tid <= t + 2'd1;
		isr_pc <= isr + 32'h40;
		@(posedge clk);
		irq_valid <= 1'b0;
		random_bits(2, v);
		decoys = int'(v[1:0]);
		for (int i = 0; i <= decoys; i++) begin
			random_bits(4, v);
			drive_decoy(0, w, isr, v[1:0]);
			drive_decoy(1, w, isr, v[3:2]);
			@(negedge clk);
			check_value(32'(irq_busy), 32'd1, "irq_busy during decoys");
			check_value(32'(irq_done), 32'd0, "irq_done during decoys");
			@(posedge clk);
		end
		drive_lane(0, 1'b0, 1'b0, w, isr);
		drive_lane(1, 1'b0, 1'b0, w, isr);
		@(negedge clk);
		check_value(32'(irq_done), 32'd0, "irq_done after decoys");
		random_bits(1, v);
		done_before = done_count;
		@(posedge clk);
		drive_lane(int'(v[0]), 1'b1, 1'b1, w, isr);
		@(posedge clk);
		drive_lane(int'(v[0]), 1'b0, 1'b0, w, isr);
		cycles = 0;
		while (irq_busy && cycles < 8) begin
			@(negedge clk);
			cycles++;
		end
		check_value(32'(done_count), 32'(done_before + 1), "irq_done pulses");
	endtask

	// compares the DUT with the shadow wherever the controller is idle
	initial begin
		forever begin
			@(negedge clk);
			if (rst_n) begin
				if (irq_done) begin
					done_count++;
					check_value(32'(exp_abort), 32'd0, "irq_done where an abort was due");
					shadow_active = exp_result.active;
					shadow_mask[exp_wid] = exp_result.mask;
				end
				if (irq_abort) begin
					abort_count++;
					check_value(32'(exp_abort), 32'd1, "irq_abort where a transfer was due");
				end
				if (!irq_busy) begin
					check_value(32'(scheduling_paused), 32'd0, "scheduling_paused");
					check_value(32'(active_warps), 32'(shadow_active), "active_warps");
					for (int w = 0; w < `NUM_WARPS; w++) begin
						check_value(32'(thread_masks[w]), 32'(shadow_mask[w]),
						            $sformatf("thread_masks[%0d]", w));
						check_value(warp_pcs[w], shadow_pc[w], $sformatf("warp_pcs[%0d]", w));
					end
				end
			end
		end
	end

	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout after %0d cycles, the test sequence did not finish", cycle_count);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		logic [31:0] v;
		int total;
		rst_n = 1'b0;
		irq_valid = 1'b0;
		irq_wid = '0;
		irq_tid = '0;
		isr_pc = '0;
		no_pending_instr = 1'b1;
		barrier_stalls = '0;
		ipdom_stack_empty = '1;
		branch_valid = '0;
		branch_taken = '0;
		branch_wid = '0;
		branch_dest = '0;
		lfsr_state = 32'h8590;
		exp_abort = 1'b0;
		exp_wid = '0;
		exp_result = '0;
		// expected reset contents follow the address map
		shadow_active = '1;
		for (int w = 0; w < `NUM_WARPS; w++) begin
			shadow_mask[w] = '1;
			shadow_pc[w] = pc_t'(`WARP_PC_BASE + w * `WARP_PC_STRIDE);
		end
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value(32'(irq_busy), 32'd0, "irq_busy after reset");
		random_bits(4, v);
		run_request(v[1:0], v[3:2], 1'b1);
		repeat (24) begin
			random_bits(4, v);
			run_request(v[1:0], v[3:2], 1'b0);
		end
		// empty warp 3 one thread at a time and knock on it twice more
		for (int t = 0; t < `NUM_THREADS; t++) begin
			run_request(2'd3, thread_id_t'(t), 1'b0);
		end
		run_request(2'd3, 2'd0, 1'b0);
		run_request(2'd3, 2'd2, 1'b0);
		repeat (2) @(negedge clk);
		total = mismatch_count + other_errors + int'(u_simt_irq_top.u_simt_irq_chk.assert_fails);
		$display("done %0d, aborted %0d, mismatches %0d, other errors %0d, assertion failures %0d",
		         done_count, abort_count, mismatch_count, other_errors,
		         u_simt_irq_top.u_simt_irq_chk.assert_fails);
		if (total == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/simt_irq_chk.sv
`default_nettype none

module simt_irq_chk (
	input  logic                       clk,
	input  logic                       rst_n,
	input  irq_state_pkg::irqc_state_t state,
	input  logic                       swap_schedule_data,
	input  warp_types_pkg::wmask_t     load_wmask,
	input  logic                       irq_done,
	input  logic                       irq_abort,
	input  logic                       irq_busy
);
	import irq_state_pkg::*;

	// assertion failures seen so far
	int unsigned assert_fails = 0;

	// the table may only be written by the swap and by the restore
	swap_only_in_swap_states: assert property (@(posedge clk) disable iff (!rst_n)
		swap_schedule_data |-> (state == IRQC_PC_SWAP || state == IRQC_REVERT_WARP))
	else begin
		$error("table written outside PC_SWAP and REVERT_WARP");
		assert_fails++;
	end

	// during the swap only the warp running the ISR stays active
	swap_wmask_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		(state == IRQC_PC_SWAP) |-> $onehot(load_wmask))
	else begin
		$error("warp mask loaded in PC_SWAP is not one-hot");
		assert_fails++;
	end

	done_abort_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(irq_done && irq_abort))
	else begin
		$error("irq_done and irq_abort are high together");
		assert_fails++;
	end

	// reset leaves the controller idle
	idle_after_reset: assert property (@(posedge clk) !rst_n |=> !irq_busy)
	else begin
		$error("irq_busy is high in the cycle after reset");
		assert_fails++;
	end

endmodule

bind simt_irq_top simt_irq_chk u_simt_irq_chk (
	.clk                (clk),
	.rst_n              (rst_n),
	.state              (u_irqc_ttu_if.state),
	.swap_schedule_data (swap_schedule_data),
	.load_wmask         (load_wmask),
	.irq_done           (irq_done),
	.irq_abort          (irq_abort),
	.irq_busy           (irq_busy)
);

`default_nettype wire

// File: source/simt_irq_top.sv
`default_nettype none

`include "simt_irq_params.svh"

module simt_irq_top (
	input  logic                                      clk,
	input  logic                                      rst_n,
	input  logic                                      irq_valid,
	input  warp_types_pkg::warp_id_t                  irq_wid,
	input  warp_types_pkg::thread_id_t                irq_tid,
	input  warp_types_pkg::pc_t                       isr_pc,
	input  logic                                      no_pending_instr,
	input  warp_types_pkg::wmask_t                    barrier_stalls,
	input  warp_types_pkg::wmask_t                    ipdom_stack_empty,
	input  logic [`ISSUE_CNT-1:0]                     branch_valid,
	input  logic [`ISSUE_CNT-1:0]                     branch_taken,
	input  warp_types_pkg::warp_id_t [`ISSUE_CNT-1:0] branch_wid,
	input  warp_types_pkg::pc_t [`ISSUE_CNT-1:0]      branch_dest,
	output logic                                      irq_busy,
	output logic                                      irq_done,
	output logic                                      irq_abort,
	output logic                                      scheduling_paused,
	output warp_types_pkg::wmask_t                    active_warps,
	output warp_types_pkg::tmask_t [`NUM_WARPS-1:0]   thread_masks,
	output warp_types_pkg::pc_t [`NUM_WARPS-1:0]      warp_pcs
);
	import warp_types_pkg::*;

	logic wd_run;
	logic wd_expired;

	// load path from the transfer unit into the table
	logic swap_schedule_data;
	pc_t load_PC;
	tmask_t load_tmask;
	wmask_t load_wmask;
	warp_id_t load_wid;

	irqc_ttu_if u_irqc_ttu_if ();

	irq_controller u_irq_controller (
		.clk        (clk),
		.rst_n      (rst_n),
		.irq_valid  (irq_valid),
		.irq_wid    (irq_wid),
		.irq_tid    (irq_tid),
		.isr_pc     (isr_pc),
		.wd_expired (wd_expired),
		.wd_run     (wd_run),
		.irq_busy   (irq_busy),
		.irq_done   (irq_done),
		.irq_abort  (irq_abort),
		.ctl        (u_irqc_ttu_if.controller)
	);

	drain_watchdog u_drain_watchdog (
		.clk        (clk),
		.rst_n      (rst_n),
		.wd_run     (wd_run),
		.wd_expired (wd_expired)
	);

	thread_transfer_unit u_thread_transfer_unit (
		.ttu                (u_irqc_ttu_if.ttu),
		.no_pending_instr   (no_pending_instr),
		.barrier_stalls     (barrier_stalls),
		.ipdom_stack_empty  (ipdom_stack_empty),
		.active_warps       (active_warps),
		.thread_masks       (thread_masks),
		.warp_pcs           (warp_pcs),
		.branch_valid       (branch_valid),
		.branch_taken       (branch_taken),
		.branch_wid         (branch_wid),
		.branch_dest        (branch_dest),
		.scheduling_paused  (scheduling_paused),
		.swap_schedule_data (swap_schedule_data),
		.load_PC            (load_PC),
		.load_tmask         (load_tmask),
		.load_wmask         (load_wmask),
		.load_wid           (load_wid)
	);

	warp_mask_table u_warp_mask_table (
		.clk                (clk),
		.rst_n              (rst_n),
		.swap_schedule_data (swap_schedule_data),
		.load_PC            (load_PC),
		.load_tmask         (load_tmask),
		.load_wmask         (load_wmask),
		.load_wid           (load_wid),
		.active_warps       (active_warps),
		.thread_masks       (thread_masks),
		.warp_pcs           (warp_pcs)
	);

endmodule

`default_nettype wire

// File: source/warp_mask_table.sv
`default_nettype none

`include "simt_irq_params.svh"

module warp_mask_table (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    swap_schedule_data,
	input  warp_types_pkg::pc_t                     load_PC,
	input  warp_types_pkg::tmask_t                  load_tmask,
	input  warp_types_pkg::wmask_t                  load_wmask,
	input  warp_types_pkg::warp_id_t                load_wid,
	output warp_types_pkg::wmask_t                  active_warps,
	output warp_types_pkg::tmask_t [`NUM_WARPS-1:0] thread_masks,
	output warp_types_pkg::pc_t [`NUM_WARPS-1:0]    warp_pcs
);
	import warp_types_pkg::*;

	// stands in for the scheduler's warp state, which the interrupt path rewrites
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// every warp starts active with all of its threads
			active_warps <= '1;
			for (int w = 0; w < `NUM_WARPS; w++) begin
				thread_masks[w] <= '1;
				// warps start on their own code, one stride apart
				warp_pcs[w] <= pc_t'(`WARP_PC_BASE + w * `WARP_PC_STRIDE);
			end
		end else if (swap_schedule_data) begin
			// the whole active set is replaced, but only one warp's mask and PC
			active_warps <= load_wmask;
			thread_masks[load_wid] <= load_tmask;
			warp_pcs[load_wid] <= load_PC;
		end
	end

endmodule

`default_nettype wire

// File: source/thread_transfer_unit.sv
`default_nettype none

`include "simt_irq_params.svh"

module thread_transfer_unit (
	irqc_ttu_if.ttu                                    ttu,
	input  logic                                       no_pending_instr,
	input  warp_types_pkg::wmask_t                     barrier_stalls,
	input  warp_types_pkg::wmask_t                     ipdom_stack_empty,
	input  warp_types_pkg::wmask_t                     active_warps,
	input  warp_types_pkg::tmask_t [`NUM_WARPS-1:0]    thread_masks,
	input  warp_types_pkg::pc_t [`NUM_WARPS-1:0]       warp_pcs,
	input  logic [`ISSUE_CNT-1:0]                      branch_valid,
	input  logic [`ISSUE_CNT-1:0]                      branch_taken,
	input  warp_types_pkg::warp_id_t [`ISSUE_CNT-1:0]  branch_wid,
	input  warp_types_pkg::pc_t [`ISSUE_CNT-1:0]       branch_dest,
	output logic                                       scheduling_paused,
	output logic                                       swap_schedule_data,
	output warp_types_pkg::pc_t                        load_PC,
	output warp_types_pkg::tmask_t                     load_tmask,
	output warp_types_pkg::wmask_t                     load_wmask,
	output warp_types_pkg::warp_id_t                   load_wid
);
	import warp_types_pkg::*;
	import irq_state_pkg::*;

	logic jump_valid;
	tmask_t kept_tmask;

	// the ISR ends with a taken branch of the request's warp back to its entry
	always_comb begin
		jump_valid = 1'b0;
		for (int i = 0; i < `ISSUE_CNT; i++) begin
			if (branch_valid[i] && branch_taken[i] && branch_wid[i] == ttu.wid &&
			    branch_dest[i] == ttu.load_PC) begin
				jump_valid = 1'b1;
			end
		end
	end

	// status and live context towards the controller
	always_comb begin
		ttu.pipeline_drained = 1'b0;
		ttu.thread_found = 1'b0;
		ttu.current_thread_mask = '0;
		ttu.current_PC = '0;
		ttu.current_active_warps = '0;
		ttu.ISR_done = 1'b0;
		case (ttu.state)
			IRQC_WAIT: begin
				// drained means nothing in flight, no barrier held and no open divergence
				ttu.pipeline_drained = no_pending_instr & ~(|barrier_stalls) &
				                       ipdom_stack_empty[ttu.wid];
				ttu.thread_found = active_warps[ttu.wid] & thread_masks[ttu.wid][ttu.tid];
				ttu.current_thread_mask = thread_masks[ttu.wid];
				ttu.current_PC = warp_pcs[ttu.wid];
				ttu.current_active_warps = active_warps;
			end
			IRQC_PC_SWAP, IRQC_WAIT_ISR, IRQC_REVERT_WARP: begin
				ttu.pipeline_drained = 1'b1;
				ttu.thread_found = 1'b1;
				// revert reports done as well, the controller ignores it there
				ttu.ISR_done = (ttu.state == IRQC_WAIT_ISR) ? jump_valid : 1'b1;
			end
			default: ;
		endcase
	end

	// scheduler load values for the swap and for the restore
	always_comb begin
		kept_tmask = ttu.load_tmask & ~(tmask_t'(1) << ttu.tid);
		scheduling_paused = 1'b0;
		swap_schedule_data = 1'b0;
		load_PC = ttu.load_PC;
		load_tmask = '0;
		load_wmask = '0;
		load_wid = ttu.wid;
		case (ttu.state)
			IRQC_WAIT: scheduling_paused = ~(|barrier_stalls) & ipdom_stack_empty[ttu.wid];
			IRQC_PC_SWAP: begin
				// only the requested thread of the requested warp runs the ISR
				scheduling_paused = 1'b1;
				swap_schedule_data = 1'b1;
				load_tmask = tmask_t'(1) << ttu.tid;
				load_wmask = wmask_t'(1) << ttu.wid;
			end
			IRQC_REVERT_WARP: begin
				swap_schedule_data = 1'b1;
				load_tmask = kept_tmask;
				// a warp left with no threads drops out of the active set
				load_wmask = (|kept_tmask) ? ttu.load_wmask :
				             ttu.load_wmask & ~(wmask_t'(1) << ttu.wid);
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: source/drain_watchdog.sv
`default_nettype none

`include "simt_irq_params.svh"

module drain_watchdog (
	input  logic clk,
	input  logic rst_n,
	input  logic wd_run,
	output logic wd_expired
);

	localparam int CNT_W = $clog2(`DRAIN_LIMIT + 1);
	localparam logic [CNT_W-1:0] LIMIT = CNT_W'(`DRAIN_LIMIT);

	// cycles spent so far in the current wait
	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (!wd_run) begin
			// every new request starts from zero
			cnt <= '0;
		end else if (cnt != LIMIT) begin
			// saturates at the limit so expired stays up until the wait ends
			cnt <= cnt + 1'b1;
		end
	end

	// a request stuck behind barriers or divergence is dropped from here
	assign wd_expired = (cnt == LIMIT);

endmodule

`default_nettype wire

// File: source/irq_controller.sv
`default_nettype none

module irq_controller (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       irq_valid,
	input  warp_types_pkg::warp_id_t   irq_wid,
	input  warp_types_pkg::thread_id_t irq_tid,
	input  warp_types_pkg::pc_t        isr_pc,
	input  logic                       wd_expired,
	output logic                       wd_run,
	output logic                       irq_busy,
	output logic                       irq_done,
	output logic                       irq_abort,
	irqc_ttu_if.controller             ctl
);
	import warp_types_pkg::*;
	import irq_state_pkg::*;

	irqc_state_t state;
	irqc_state_t state_next;
	logic abort_next;

	// the request as it was taken in idle
	warp_id_t req_wid;
	thread_id_t req_tid;
	pc_t req_isr_pc;

	// warp context captured on the way into the swap
	tmask_t saved_tmask;
	pc_t saved_pc;
	wmask_t saved_wmask;

	always_comb begin
		state_next = state;
		abort_next = 1'b0;
		case (state)
			IRQC_IDLE: begin
				// a strobe seen in any other state is simply dropped
				if (irq_valid) begin
					state_next = IRQC_WAIT;
				end
			end
			IRQC_WAIT: begin
				// the watchdog wins over a drain seen in the same cycle
				if (wd_expired) begin
					state_next = IRQC_IDLE;
					abort_next = 1'b1;
				end else if (ctl.pipeline_drained) begin
					if (ctl.thread_found) begin
						state_next = IRQC_PC_SWAP;
					end else begin
						// thread already gone or warp inactive, nothing to hand over
						state_next = IRQC_IDLE;
						abort_next = 1'b1;
					end
				end
			end
			IRQC_PC_SWAP: state_next = IRQC_WAIT_ISR;
			IRQC_WAIT_ISR: begin
				if (ctl.ISR_done) begin
					state_next = IRQC_REVERT_WARP;
				end
			end
			default: state_next = IRQC_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IRQC_IDLE;
			irq_abort <= 1'b0;
		end else begin
			state <= state_next;
			// abort shows for one cycle, in the idle cycle after the wait
			irq_abort <= abort_next;
		end
	end

	always_ff @(posedge clk) begin
		if (state == IRQC_IDLE && irq_valid) begin
			req_wid <= irq_wid;
			req_tid <= irq_tid;
			req_isr_pc <= isr_pc;
		end
		if (state == IRQC_WAIT && state_next == IRQC_PC_SWAP) begin
			saved_tmask <= ctl.current_thread_mask;
			saved_pc <= ctl.current_PC;
			saved_wmask <= ctl.current_active_warps;
		end
	end

	assign ctl.state = state;
	assign ctl.wid = req_wid;
	assign ctl.tid = req_tid;
	// the ISR address doubles as the match target for the ISR-done jump
	assign ctl.load_PC = (state == IRQC_REVERT_WARP) ? saved_pc : req_isr_pc;
	assign ctl.load_tmask = saved_tmask;
	assign ctl.load_wmask = saved_wmask;

	assign wd_run = (state == IRQC_WAIT);
	assign irq_busy = (state != IRQC_IDLE);
	assign irq_done = (state == IRQC_REVERT_WARP);

endmodule

`default_nettype wire

// File: source/irqc_ttu_if.sv
`default_nettype none

interface irqc_ttu_if;
	import warp_types_pkg::*;
	import irq_state_pkg::*;

	// controller side, the request and the context it saved
	irqc_state_t state;
	warp_id_t wid;
	thread_id_t tid;
	pc_t load_PC;
	tmask_t load_tmask;
	wmask_t load_wmask;

	// transfer unit side, status and the live context of the warp
	logic pipeline_drained;
	logic thread_found;
	tmask_t current_thread_mask;
	pc_t current_PC;
	wmask_t current_active_warps;
	logic ISR_done;

	modport controller (
		output state, wid, tid, load_PC, load_tmask, load_wmask,
		input pipeline_drained, thread_found, current_thread_mask, current_PC,
		input current_active_warps, ISR_done
	);

	modport ttu (
		input state, wid, tid, load_PC, load_tmask, load_wmask,
		output pipeline_drained, thread_found, current_thread_mask, current_PC,
		output current_active_warps, ISR_done
	);

endinterface

`default_nettype wire

// File: source/irq_state_pkg.sv
`default_nettype none

package irq_state_pkg;

	// states of the interrupt controller, shared by the controller
	// and the transfer unit that acts on them
	typedef enum logic [2:0] {
		IRQC_IDLE        = 3'd0,
		IRQC_WAIT        = 3'd1,
		IRQC_PC_SWAP     = 3'd2,
		IRQC_WAIT_ISR    = 3'd3,
		IRQC_REVERT_WARP = 3'd4
	} irqc_state_t;

endpackage

`default_nettype wire

// File: source/warp_types_pkg.sv
`default_nettype none

`include "simt_irq_params.svh"

package warp_types_pkg;

	// index of a warp and of a thread inside a warp
	typedef logic [$clog2(`NUM_WARPS)-1:0] warp_id_t;
	typedef logic [$clog2(`NUM_THREADS)-1:0] thread_id_t;

	// one bit per thread of a warp, and one bit per warp of the core
	typedef logic [`NUM_THREADS-1:0] tmask_t;
	typedef logic [`NUM_WARPS-1:0] wmask_t;

	typedef logic [`XLEN-1:0] pc_t;

endpackage

`default_nettype wire

// File: source/simt_irq_params.svh
`ifndef SIMT_IRQ_PARAMS_SVH
`define SIMT_IRQ_PARAMS_SVH

// core geometry seen by the interrupt path
`define NUM_WARPS 4
`define NUM_THREADS 4

// program counter width in bits
`define XLEN 32

// number of branch lanes reported by execute in one cycle
`define ISSUE_CNT 2

// cycles a request may sit in the wait state before it is dropped
`define DRAIN_LIMIT 16

// warp w comes out of reset at WARP_PC_BASE + w * WARP_PC_STRIDE
`define WARP_PC_BASE 32'h1000
`define WARP_PC_STRIDE 32'h100

`endif
